//--- apb_map_pkg.sv
`default_nettype none

package apb_map_pkg;

	// byte address and data word of the host bus
	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// register offsets
	typedef enum logic [7:0] {
		REG_CTRL   = 8'h00,
		REG_STATUS = 8'h04,
		REG_MSG0   = 8'h10,
		REG_MSG1   = 8'h14,
		REG_MSG2   = 8'h18,
		REG_MSG3   = 8'h1C,
		REG_MSG4   = 8'h20,
		REG_MSG5   = 8'h24
	} reg_addr_t;

	// control and status bit positions
	localparam int CTRL_START_BIT  = 0;
	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_DONE_BIT = 1;

	// four characters per message word
	localparam int MSG_WORDS = 6;

endpackage

`default_nettype wire

//--- lcd_ctrl_pkg.sv
`default_nettype none

package lcd_ctrl_pkg;

	typedef logic [7:0] lcd_byte_t;
	typedef logic [4:0] char_idx_t;

	// two rows of the display
	localparam int ROW_CHARS = 12;
	localparam int MSG_CHARS = 2 * ROW_CHARS;

	// HD44780 instruction bytes
	typedef enum logic [7:0] {
		CMD_FUNC_SET   = 8'h38,
		CMD_DISP_OFF   = 8'h08,
		CMD_CLEAR      = 8'h01,
		CMD_ENTRY_MODE = 8'h06,
		CMD_DISP_ON    = 8'h0C,
		CMD_ROW1_ADDR  = 8'h80,
		CMD_ROW2_ADDR  = 8'hC0
	} lcd_cmd_t;

	// one state per byte kind offered to the bus driver
	typedef enum logic [3:0] {
		ST_STARTUP,
		ST_READY,
		ST_FUNC_SET,
		ST_DISP_OFF,
		ST_CLEAR,
		ST_ENTRY_MODE,
		ST_DISP_ON,
		ST_ROW1_ADDR,
		ST_ROW1_CHARS,
		ST_ROW2_ADDR,
		ST_ROW2_CHARS,
		ST_FINISH
	} seq_state_t;

endpackage

`default_nettype wire

//--- apb_msg_regs.sv
`default_nettype none

module apb_msg_regs (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  apb_map_pkg::apb_addr_t  paddr,
	input  apb_map_pkg::apb_data_t  pwdata,
	output apb_map_pkg::apb_data_t  prdata,
	output logic                    pready,
	output logic                    pslverr,
	output logic                    start,
	input  lcd_ctrl_pkg::char_idx_t char_idx,
	output lcd_ctrl_pkg::lcd_byte_t char_data,
	input  logic                    busy,
	input  logic                    done
);
	import apb_map_pkg::*;
	import lcd_ctrl_pkg::*;

	apb_data_t  msg_mem [MSG_WORDS];
	apb_data_t  rd_word;
	logic       access;
	logic       addr_ok;
	logic       is_ctrl;
	logic       is_msg;
	logic       start_req;
	logic [2:0] msg_sel;

	assign access    = psel && penable;
	assign start_req = is_ctrl && pwdata[CTRL_START_BIT];
	assign pready    = 1'b1;

	// offsets 0x10..0x24 land on words 0..5 once bit 5 wraps away
	assign msg_sel = paddr[4:2] - 3'd4;

	always_comb begin
		addr_ok = 1'b1;
		is_ctrl = 1'b0;
		is_msg  = 1'b0;
		rd_word = '0;
		case (paddr)
			REG_CTRL: begin
				is_ctrl = 1'b1;
			end
			REG_STATUS: begin
				rd_word[STATUS_BUSY_BIT] = busy;
				rd_word[STATUS_DONE_BIT] = done;
			end
			REG_MSG0, REG_MSG1, REG_MSG2, REG_MSG3, REG_MSG4, REG_MSG5: begin
				is_msg  = 1'b1;
				rd_word = msg_mem[msg_sel];
			end
			default: begin
				addr_ok = 1'b0;
			end
		endcase
	end

	assign prdata = (psel && !pwrite) ? rd_word : '0;

	// message and start are locked while a transfer runs
	assign pslverr = access && (!addr_ok || (pwrite && busy && (is_msg || start_req)));

	always_ff @(posedge clk) begin
		if (access && pwrite && is_msg && !busy)
			msg_mem[msg_sel] <= pwdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			start <= 1'b0;
		else
			start <= access && pwrite && start_req && !busy;
	end

	// lowest byte of a word is the first character
	always_comb begin
		char_data = '0;
		if (char_idx < MSG_CHARS)
			char_data = msg_mem[char_idx[4:2]][{char_idx[1:0], 3'b000} +: 8];
	end

endmodule

`default_nettype wire

//--- lcd_sequencer.sv
`default_nettype none

module lcd_sequencer #(
	parameter int STARTUP_CYCLES = 750000
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	output lcd_ctrl_pkg::char_idx_t char_idx,
	input  lcd_ctrl_pkg::lcd_byte_t char_data,
	output logic                    byte_valid,
	output logic                    byte_rs,
	output lcd_ctrl_pkg::lcd_byte_t byte_data,
	input  logic                    byte_ready,
	output logic                    busy,
	output logic                    done
);
	import lcd_ctrl_pkg::*;

	localparam int WAIT_W = $clog2(STARTUP_CYCLES + 1);

	seq_state_t        state;
	seq_state_t        next_state;
	logic [WAIT_W-1:0] wait_cnt;
	char_idx_t         char_cnt;
	logic              func_again;
	logic              take;

	assign char_idx = char_cnt;
	assign take     = byte_valid && byte_ready;

	always_comb begin
		next_state = state;
		byte_valid = 1'b1;
		byte_rs    = 1'b0;
		byte_data  = '0;
		case (state)
			ST_STARTUP: begin
				byte_valid = 1'b0;
				if (wait_cnt == WAIT_W'(STARTUP_CYCLES - 1))
					next_state = ST_READY;
			end
			ST_READY, ST_FINISH: begin
				byte_valid = 1'b0;
				if (start)
					next_state = ST_FUNC_SET;
			end
			// function set goes out twice after a start
			ST_FUNC_SET: begin
				byte_data = CMD_FUNC_SET;
				if (take && !func_again)
					next_state = ST_DISP_OFF;
			end
			ST_DISP_OFF: begin
				byte_data = CMD_DISP_OFF;
				if (take)
					next_state = ST_CLEAR;
			end
			ST_CLEAR: begin
				byte_data = CMD_CLEAR;
				if (take)
					next_state = ST_ENTRY_MODE;
			end
			ST_ENTRY_MODE: begin
				byte_data = CMD_ENTRY_MODE;
				if (take)
					next_state = ST_DISP_ON;
			end
			ST_DISP_ON: begin
				byte_data = CMD_DISP_ON;
				if (take)
					next_state = ST_ROW1_ADDR;
			end
			ST_ROW1_ADDR: begin
				byte_data = CMD_ROW1_ADDR;
				if (take)
					next_state = ST_ROW1_CHARS;
			end
			ST_ROW1_CHARS: begin
				byte_rs   = 1'b1;
				byte_data = char_data;
				if (take && char_cnt == char_idx_t'(ROW_CHARS - 1))
					next_state = ST_ROW2_ADDR;
			end
			ST_ROW2_ADDR: begin
				byte_data = CMD_ROW2_ADDR;
				if (take)
					next_state = ST_ROW2_CHARS;
			end
			ST_ROW2_CHARS: begin
				byte_rs   = 1'b1;
				byte_data = char_data;
				if (take && char_cnt == char_idx_t'(MSG_CHARS - 1))
					next_state = ST_FINISH;
			end
			default: begin
				byte_valid = 1'b0;
				next_state = ST_READY;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= ST_STARTUP;
			wait_cnt   <= '0;
			char_cnt   <= '0;
			func_again <= 1'b0;
			busy       <= 1'b0;
			done       <= 1'b0;
		end else begin
			state <= next_state;
			if (state == ST_STARTUP) begin
				wait_cnt <= wait_cnt + 1'b1;
				busy     <= (next_state == ST_STARTUP);
			end
			if ((state == ST_READY || state == ST_FINISH) && start) begin
				char_cnt   <= '0;
				func_again <= 1'b1;
				busy       <= 1'b1;
				done       <= 1'b0;
			end else if (state == ST_FINISH && busy && byte_ready) begin
				// last strobe has fallen, nothing left pending
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (take && state == ST_FUNC_SET)
				func_again <= 1'b0;
			if (take && (state == ST_ROW1_CHARS || state == ST_ROW2_CHARS))
				char_cnt <= char_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- lcd_bus_driver.sv
`default_nettype none

module lcd_bus_driver #(
	parameter int HALF_PERIOD = 50000
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    byte_valid,
	input  logic                    byte_rs,
	input  lcd_ctrl_pkg::lcd_byte_t byte_data,
	output logic                    byte_ready,
	output logic                    lcd_rs,
	output logic                    lcd_en,
	output lcd_ctrl_pkg::lcd_byte_t lcd_data
);

	localparam int PH_W = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;

	logic [PH_W-1:0] phase_cnt;
	logic            phase_end;

	assign phase_end = (phase_cnt == PH_W'(HALF_PERIOD - 1));

	// byte_ready low marks a running transfer, lcd_en tells the phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			byte_ready <= 1'b1;
			lcd_en     <= 1'b0;
			lcd_rs     <= 1'b0;
			lcd_data   <= '0;
			phase_cnt  <= '0;
		end else if (byte_ready) begin
			if (byte_valid) begin
				byte_ready <= 1'b0;
				lcd_rs     <= byte_rs;
				lcd_data   <= byte_data;
				phase_cnt  <= '0;
			end
		end else if (phase_end) begin
			phase_cnt  <= '0;
			lcd_en     <= !lcd_en;
			// free again as the strobe falls
			byte_ready <= lcd_en;
		end else begin
			phase_cnt <= phase_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- lcd_message_top.sv
`default_nettype none

module lcd_message_top #(
	parameter int STARTUP_CYCLES = 750000,
	parameter int HALF_PERIOD    = 50000
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  apb_map_pkg::apb_addr_t  paddr,
	input  apb_map_pkg::apb_data_t  pwdata,
	output apb_map_pkg::apb_data_t  prdata,
	output logic                    pready,
	output logic                    pslverr,
	output logic                    lcd_rs,
	output logic                    lcd_rw,
	output logic                    lcd_en,
	output lcd_ctrl_pkg::lcd_byte_t lcd_data
);
	import lcd_ctrl_pkg::*;

	logic      start;
	logic      busy;
	logic      done;
	char_idx_t char_idx;
	lcd_byte_t char_data;
	logic      byte_valid;
	logic      byte_rs;
	lcd_byte_t byte_data;
	logic      byte_ready;

	// write-only display
	assign lcd_rw = 1'b0;

	apb_msg_regs u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.start     (start),
		.char_idx  (char_idx),
		.char_data (char_data),
		.busy      (busy),
		.done      (done)
	);

	lcd_sequencer #(
		.STARTUP_CYCLES (STARTUP_CYCLES)
	) u_seq (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.char_idx   (char_idx),
		.char_data  (char_data),
		.byte_valid (byte_valid),
		.byte_rs    (byte_rs),
		.byte_data  (byte_data),
		.byte_ready (byte_ready),
		.busy       (busy),
		.done       (done)
	);

	lcd_bus_driver #(
		.HALF_PERIOD (HALF_PERIOD)
	) u_drv (
		.clk        (clk),
		.rst_n      (rst_n),
		.byte_valid (byte_valid),
		.byte_rs    (byte_rs),
		.byte_data  (byte_data),
		.byte_ready (byte_ready),
		.lcd_rs     (lcd_rs),
		.lcd_en     (lcd_en),
		.lcd_data   (lcd_data)
	);

endmodule

`default_nettype wire

//--- tb_lcd_message.sv
`default_nettype none

module tb_lcd_message;
	timeunit 1ns;
	timeprecision 100ps;

	import apb_map_pkg::*;
	import lcd_ctrl_pkg::*;

	localparam int STARTUP_CYCLES = 200;
	localparam int HALF_PERIOD    = 4;
	localparam int CLK_HALF       = 4;
	localparam int SAMPLE_DELAY   = 2;
	localparam int APB_TIMEOUT    = 20;
	localparam int POLL_LIMIT     = 1000;

	logic      clk;
	logic      rst_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;
	logic      lcd_rs;
	logic      lcd_rw;
	logic      lcd_en;
	lcd_byte_t lcd_data;

	int        checks_run;
	int        errors_seen;
	logic      run_aborted;
	logic      exp_rs_q[$];
	lcd_byte_t exp_data_q[$];
	logic      mon_rs_q[$];
	lcd_byte_t mon_data_q[$];
	logic      en_prev;
	int        high_cycles;
	logic      held_rs;
	lcd_byte_t held_data;

	lcd_message_top #(
		.STARTUP_CYCLES (STARTUP_CYCLES),
		.HALF_PERIOD    (HALF_PERIOD)
	) dut0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.lcd_rs   (lcd_rs),
		.lcd_rw   (lcd_rw),
		.lcd_en   (lcd_en),
		.lcd_data (lcd_data)
	);

	always #CLK_HALF clk = !clk;

	task automatic abort_run(input string why);
		$display("run stopped at %0t: %s", $time, why);
		run_aborted = 1'b1;
	endtask

	task automatic check_word(input string what, input apb_data_t got, input apb_data_t exp);
		checks_run++;
		if (got !== exp) begin
			errors_seen++;
			$display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_byte(input string what, input logic got_rs, input lcd_byte_t got,
			input logic exp_rs, input lcd_byte_t exp);
		checks_run++;
		if (got_rs !== exp_rs || got !== exp) begin
			errors_seen++;
			$display("ERR %0t %s: got rs=%b data=%h, expected rs=%b data=%h",
				$time, what, got_rs, got, exp_rs, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		checks_run++;
		if (got !== exp) begin
			errors_seen++;
			$display("ERR %0t %s: got %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks_run++;
		if (got != exp) begin
			errors_seen++;
			$display("ERR %0t %s: got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// one APB3 transfer, setup then access, sampled ahead of the completing edge
	task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic err);
		int waits;
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		#SAMPLE_DELAY;
		waits = 0;
		while (!pready && !run_aborted) begin
			waits++;
			if (waits > APB_TIMEOUT)
				abort_run("pready stayed low on an APB access");
			else begin
				@(negedge clk);
				#SAMPLE_DELAY;
			end
		end
		rdata = prdata;
		err   = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
		apb_data_t rdata;
		logic      err;
		apb_access(1'b1, addr, data, rdata, err);
		check_flag($sformatf("pslverr of write to %h", addr), err, exp_err);
	endtask

	task automatic apb_read(input apb_addr_t addr, input apb_data_t exp, input logic exp_err);
		apb_data_t rdata;
		logic      err;
		apb_access(1'b0, addr, '0, rdata, err);
		check_word($sformatf("read of %h", addr), rdata, exp);
		check_flag($sformatf("pslverr of read from %h", addr), err, exp_err);
	endtask

	task automatic poll_status(input apb_data_t mask, input apb_data_t value);
		apb_data_t word;
		logic      err;
		int        polls;
		polls = 0;
		apb_access(1'b0, REG_STATUS, '0, word, err);
		while ((word & mask) != value && !run_aborted) begin
			polls++;
			if (polls > POLL_LIMIT)
				abort_run("status register never reached the expected value");
			else
				apb_access(1'b0, REG_STATUS, '0, word, err);
		end
		check_flag("pslverr of status read", err, 1'b0);
	endtask

	task automatic compare_stream();
		int i;
		check_count("bytes on the bus", mon_data_q.size(), exp_data_q.size());
		for (i = 0; i < exp_data_q.size() && i < mon_data_q.size(); i++)
			check_byte($sformatf("bus byte %0d", i), mon_rs_q[i], mon_data_q[i],
				exp_rs_q[i], exp_data_q[i]);
		exp_rs_q.delete();
		exp_data_q.delete();
		mon_rs_q.delete();
		mon_data_q.delete();
	endtask

	task automatic report_test(input logic [255:0] name, input int errs);
		$display("test %0s: %0s, %0d errors", name, (errs == 0) ? "ok" : "bad", errs);
	endtask

	// bus monitor, strobe width and bus stability
	always @(negedge clk) begin
		if (!rst_n) begin
			en_prev     = 1'b0;
			high_cycles = 0;
		end else begin
			if (lcd_en) begin
				if (!en_prev) begin
					held_rs     = lcd_rs;
					held_data   = lcd_data;
					high_cycles = 0;
				end else begin
					check_byte("bus while strobe high", lcd_rs, lcd_data, held_rs, held_data);
				end
				high_cycles++;
			end else if (en_prev) begin
				check_count("strobe high width", high_cycles, HALF_PERIOD);
				check_flag("lcd_rw during transfer", lcd_rw, 1'b0);
				mon_rs_q.push_back(held_rs);
				mon_data_q.push_back(held_data);
			end
			en_prev = lcd_en;
		end
	end

	initial begin
		int             fd;
		int             n;
		int             count;
		int             test_base;
		logic           test_open;
		logic [63:0]    kind;
		logic [255:0]   test_name;
		logic [1023:0]  skip_line;
		logic [11:0]    tok;
		apb_addr_t      addr;
		apb_data_t      data;
		apb_data_t      mask;
		logic           err;
		clk         = 1'b0;
		rst_n       = 1'b0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		checks_run  = 0;
		errors_seen = 0;
		run_aborted = 1'b0;
		test_base   = 0;
		test_open   = 1'b0;
		test_name   = "reset";
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_flag("lcd_en after reset", lcd_en, 1'b0);
		check_flag("lcd_rw after reset", lcd_rw, 1'b0);
		check_byte("bus after reset", lcd_rs, lcd_data, 1'b0, 8'h00);

		fd = $fopen("lcd_vectors.txt", "r");
		if (fd == 0)
			abort_run("cannot open lcd_vectors.txt");
		while (fd != 0 && !run_aborted && !$feof(fd)) begin
			n = $fscanf(fd, "%s", kind);
			if (n != 1)
				break;
			case (kind)
				"#": n = $fgets(skip_line, fd);
				"T": begin
					if (test_open) begin
						report_test(test_name, errors_seen - test_base);
						test_base = errors_seen;
					end
					n = $fscanf(fd, "%s", test_name);
					test_open = 1'b1;
				end
				"W": begin
					n = $fscanf(fd, "%h %h %h", addr, data, err);
					apb_write(addr, data, err);
				end
				"R": begin
					n = $fscanf(fd, "%h %h %h", addr, data, err);
					apb_read(addr, data, err);
				end
				"S": apb_write(REG_CTRL, 32'h0000_0001, 1'b0);
				"P": begin
					n = $fscanf(fd, "%h %h", mask, data);
					poll_status(mask, data);
				end
				"L": begin
					n = $fscanf(fd, "%d", count);
					repeat (count) begin
						n = $fscanf(fd, "%h", tok);
						exp_rs_q.push_back(tok[8]);
						exp_data_q.push_back(tok[7:0]);
					end
				end
				"D": begin
					// done set and busy clear, then the whole stream
					poll_status(32'h0000_0003, 32'h0000_0002);
					compare_stream();
				end
				default: abort_run("unknown item in lcd_vectors.txt");
			endcase
		end
		if (fd != 0)
			$fclose(fd);
		if (test_open)
			report_test(test_name, errors_seen - test_base);

		$display("checks %0d, errors %0d", checks_run, errors_seen);
		if (errors_seen == 0 && !run_aborted) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- lcd_vectors.txt
# W addr data err | R addr data err | S start | P mask value | D wait done, compare bytes
# L count, then count items with rs in bit 8 and the byte below | T test name
T reset_and_readback
R 04 00000001 0
P 00000003 00000000
W 10 4C4C4548 0
W 14 4F57204F 0
W 18 21444C52 0
W 1C 2044434C 0
W 20 20414956 0
W 24 21425041 0
R 10 4C4C4548 0
R 14 4F57204F 0
R 18 21444C52 0
R 1C 2044434C 0
R 20 20414956 0
R 24 21425041 0
R 00 00000000 0
T locked_during_run
L 7 038 038 008 001 006 00C 080
L 12 148 145 14C 14C 14F 120 157 14F 152 14C 144 121
L 1 0C0
L 12 14C 143 144 120 156 149 141 120 141 150 142 121
S
W 18 DEADBEEF 1
W 00 00000001 1
W 30 12345678 1
R 30 00000000 1
T first_message
D
R 18 21444C52 0
T second_message
W 10 4F434553 0
W 14 5220444E 0
W 18 32204E55 0
W 1C 2057454E 0
W 20 54584554 0
W 24 214B4F20 0
L 7 038 038 008 001 006 00C 080
L 12 153 145 143 14F 14E 144 120 152 155 14E 120 132
L 1 0C0
L 12 14E 145 157 120 154 145 158 154 120 14F 14B 121
S
R 04 00000001 0
D

//--- sim.f
apb_map_pkg.sv
lcd_ctrl_pkg.sv
apb_msg_regs.sv
lcd_sequencer.sv
lcd_bus_driver.sv
lcd_message_top.sv
tb_lcd_message.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary -Wno-fatal --top-module tb_lcd_message -Mdir obj_dir \
	-o tb_lcd_message -f sim.f > build.log 2>&1 \
	&& ./obj_dir/tb_lcd_message > sim.log 2>&1 \
	&& cat sim.log \
	&& ! grep -q "TESTBENCH FAILED" sim.log \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }
